// ==== saturnPkg.sv ====
`default_nettype none

package saturnPkg;

	parameter int CpuAddrWidth   = 25;
	parameter int CpuDataWidth   = 32;
	parameter int BusDataWidth   = 16;
	parameter int CdAddrWidth    = 21; // Word address, bits 21..1
	parameter int CdRamAddrWidth = 18;

	// Master CPU cycle as seen by the glue
	typedef struct packed {
		logic [CpuAddrWidth-1:0] addr;
		logic [CpuDataWidth-1:0] wdata;
		logic [3:0]              dqmN;  // Byte enables
		logic                    rdN;
		logic                    cs3N;  // High RAM
	} cpuBus_t;

	// Selects from the external address decoder
	typedef struct packed {
		logic dramN;
		logic romN;
		logic sramN;
		logic smpcN;
	} chipSel_t;

	// CD sub-CPU bus
	typedef struct packed {
		logic [CdAddrWidth-1:0]  addr;
		logic [BusDataWidth-1:0] wdata;
		logic                    wrlN;
		logic                    wrhN;
		logic                    rdN;
		logic                    cs1N;  // CD RAM
	} cdBus_t;

	typedef struct packed {
		logic vdp1N;
		logic vdp2N;
		logic scspN;
	} bSel_t;

endpackage

`default_nettype wire

// ==== clockEnableGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockEnableGen #(
	parameter int SmpcDivide = 7
) (
	input  wire  CLK,
	input  wire  RST_N,
	input  logic ce,
	input  logic pauseEn,
	output logic ceRise,
	output logic ceFall,
	output logic smpcCe,
	output logic masterResN
);

	localparam int CntWidth = (SmpcDivide > 1) ? $clog2(SmpcDivide) : 1;
	localparam logic [CntWidth-1:0] CntLast = CntWidth'(SmpcDivide - 1);

	logic                mclk;
	logic [CntWidth-1:0] divCnt;

	// Phase bit, frozen while paused
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			mclk <= 1'b0;
		end else if (ce && !pauseEn) begin
			mclk <= ~mclk;
		end
	end

	assign ceRise =  mclk & ~pauseEn;
	assign ceFall = ~mclk & ~pauseEn;

	// System manager enable, one CLK wide
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			divCnt     <= '0;
			smpcCe     <= 1'b0;
			masterResN <= 1'b0;
		end else begin
			smpcCe <= 1'b0;
			if (ceRise) begin
				if (divCnt == CntLast) begin
					divCnt <= '0;
					smpcCe <= 1'b1;
				end else begin
					divCnt <= divCnt + 1'b1;
				end
			end
			if (smpcCe) masterResN <= 1'b1; // Held high until next reset
		end
	end

	// Wrap restarts the count so pulses never merge
	assert property (@(posedge CLK) disable iff (!RST_N)
		(SmpcDivide > 1) && smpcCe |=> !smpcCe)
		else $error("smpcCe wider than one CLK");

endmodule

`default_nettype wire

// ==== busArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
	input  wire  CLK,
	input  wire  RST_N,
	input  logic ceRise,
	input  logic sshReqN,
	input  logic scuReqN,
	input  logic masterGrantN,
	output logic masterRelN,
	output logic sshAckN,
	output logic scuAckN
);

	logic sshActive;
	logic scuActive;

	// Ownership of the master bus, slave CPU first
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			sshActive <= 1'b0;
			scuActive <= 1'b0;
		end else if (ceRise) begin
			if (!sshReqN && !sshActive && !scuActive) begin
				sshActive <= 1'b1;
			end else if (sshReqN && sshActive) begin
				sshActive <= 1'b0;
			end

			if (!scuReqN && sshReqN && !scuActive && !sshActive) begin
				scuActive <= 1'b1;
			end else if (scuReqN && scuActive) begin
				scuActive <= 1'b0;
			end
		end
	end

	// Release asked while the owner keeps its request
	assign masterRelN = (sshReqN | ~sshActive) & (scuReqN | ~scuActive);

	assign sshAckN = masterGrantN | ~sshActive;
	assign scuAckN = masterGrantN | ~scuActive;

	// Only one owner of the master bus
	assert property (@(posedge CLK) disable iff (!RST_N) !(sshActive && scuActive))
		else $error("Both bus owners active");

endmodule

`default_nettype wire

// ==== systemReadMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module systemReadMux (
	input  saturnPkg::cpuBus_t                      cpuBus,
	input  saturnPkg::chipSel_t                     chipSel,
	input  logic [saturnPkg::CpuDataWidth-1:0]      memRdata,
	input  logic [7:0]                              smpcData,
	input  logic [saturnPkg::CpuDataWidth-1:0]      scuRdata,
	input  logic                                    memWaitN,
	input  logic                                    ctrlWaitN,
	output logic [saturnPkg::CpuDataWidth-1:0]      cpuRdata,
	output logic                                    waitN,
	input  saturnPkg::bSel_t                        bSel,
	input  logic [saturnPkg::BusDataWidth-1:0]      vdp1Data,
	input  logic [saturnPkg::BusDataWidth-1:0]      vdp2Data,
	input  logic [saturnPkg::BusDataWidth-1:0]      scspData,
	output logic [saturnPkg::BusDataWidth-1:0]      bRdata,
	output logic [3:0]                              memCsN
);

	logic memSelected;

	// Any external memory on the CPU bus
	assign memSelected = !cpuBus.cs3N || !chipSel.dramN || !chipSel.romN || !chipSel.sramN;

	always_comb begin
		if (memSelected) begin
			cpuRdata = memRdata;
		end else if (!chipSel.smpcN) begin
			cpuRdata = {4{smpcData}}; // 8-bit device on every lane
		end else begin
			cpuRdata = scuRdata;
		end
	end

	// Memory wait only counts while memory is addressed
	assign waitN = ctrlWaitN & (memWaitN | ~memSelected);

	// B-bus return data
	always_comb begin
		if (!bSel.vdp1N) begin
			bRdata = vdp1Data;
		end else if (!bSel.vdp2N) begin
			bRdata = vdp2Data;
		end else if (!bSel.scspN) begin
			bRdata = scspData;
		end else begin
			bRdata = '0;
		end
	end

	// Board order, MSB first: rom, sram, low RAM, high RAM
	assign memCsN = {chipSel.romN, chipSel.sramN, chipSel.dramN, cpuBus.cs3N};

endmodule

`default_nettype wire

// ==== cdRamBridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdRamBridge (
	input  saturnPkg::cdBus_t                       cdBus,
	input  logic [saturnPkg::BusDataWidth-1:0]      chipRdata,
	input  logic [saturnPkg::BusDataWidth-1:0]      chipWdata,
	input  logic [saturnPkg::BusDataWidth-1:0]      cdRamQ,
	input  logic                                    cdRamRdy,
	output logic [saturnPkg::BusDataWidth-1:0]      cdRdata,
	output logic                                    cdWaitN,
	output logic [saturnPkg::CdRamAddrWidth-1:0]    cdRamA,
	output logic [saturnPkg::BusDataWidth-1:0]      cdRamD,
	output logic [1:0]                              cdRamWe,
	output logic                                    cdRamRd,
	output logic                                    cdRamCs
);

	assign cdRamA  = cdBus.addr[saturnPkg::CdRamAddrWidth-1:0]; // 512 KB window
	assign cdRamD  = chipWdata;              // RAM is written from the interface chip
	assign cdRamWe = ~{cdBus.wrhN, cdBus.wrlN};
	assign cdRamCs = ~cdBus.cs1N;
	assign cdRamRd = ~cdBus.rdN;

	// RAM data while CS1 is low, else interface chip registers
	assign cdRdata = !cdBus.cs1N ? cdRamQ : chipRdata;

	assign cdWaitN = cdRamRdy;

endmodule

`default_nettype wire

// ==== debugMonitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module debugMonitor #(
	parameter logic [saturnPkg::CpuAddrWidth-1:0]   HookAddr    = 25'h0012B0,
	parameter logic [saturnPkg::CdRamAddrWidth-1:0] CdWatchAddr = 18'h3AC0C
) (
	input  wire                 CLK,
	input  wire                 RST_N,
	input  logic                ceRise,
	input  saturnPkg::cpuBus_t  cpuBus,
	input  saturnPkg::cdBus_t   cdBus,
	output logic [7:0]          waitCnt,
	output logic                hook,
	output logic [7:0]          cdWriteCnt
);

	logic cpuIdle;
	logic cdWrite;
	logic cdWriteOld;
	logic cdWatchHit;

	assign cpuIdle    = cpuBus.rdN && (&cpuBus.dqmN);
	assign cdWrite    = !cdBus.wrlN || !cdBus.wrhN;
	assign cdWatchHit = !cdBus.cs1N &&
		(cdBus.addr[saturnPkg::CdRamAddrWidth-1:0] == CdWatchAddr);

	// Cycle length and boot hook
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			waitCnt <= '0;
			hook    <= 1'b0;
		end else if (ceRise) begin
			if (cpuIdle) begin
				waitCnt <= '0;
			end else begin
				waitCnt <= waitCnt + 8'd1; // Wraps on long stalls
			end
			if (cpuBus.addr == HookAddr && !cpuBus.rdN && !cpuBus.cs3N) hook <= 1'b1;
		end
	end

	// Write edges to the watched CD RAM word
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cdWriteOld <= 1'b0;
			cdWriteCnt <= '0;
		end else if (ceRise) begin
			cdWriteOld <= cdWrite;
			if (cdWrite && !cdWriteOld && cdWatchHit) begin
				cdWriteCnt <= cdWriteCnt + 8'd1;
			end
		end
	end

	// Counted write leaves the edge flag set, so a held strobe counts once
	assert property (@(posedge CLK) disable iff (!RST_N)
		cdWriteCnt != $past(cdWriteCnt) |-> cdWriteOld)
		else $error("CD write counted without edge flag");

endmodule

`default_nettype wire

// ==== saturnInterconnect.sv ====
`timescale 1ns/1ps
`default_nettype none

module saturnInterconnect #(
	parameter int                                   SmpcDivide  = 7,
	parameter logic [saturnPkg::CpuAddrWidth-1:0]   HookAddr    = 25'h0012B0,
	parameter logic [saturnPkg::CdRamAddrWidth-1:0] CdWatchAddr = 18'h3AC0C
) (
	input  wire                                     CLK,
	input  wire                                     RST_N,
	input  logic                                    ce,
	input  logic                                    pauseEn,
	output logic                                    ceRise,
	output logic                                    ceFall,
	output logic                                    smpcCe,
	output logic                                    masterResN,

	input  logic                                    sshReqN,
	input  logic                                    scuReqN,
	input  logic                                    masterGrantN,
	output logic                                    masterRelN,
	output logic                                    sshAckN,
	output logic                                    scuAckN,

	input  saturnPkg::cpuBus_t                      cpuBus,
	input  saturnPkg::chipSel_t                     chipSel,
	input  logic [saturnPkg::CpuDataWidth-1:0]      memRdata,
	input  logic [7:0]                              smpcData,
	input  logic [saturnPkg::CpuDataWidth-1:0]      scuRdata,
	input  logic                                    memWaitN,
	input  logic                                    ctrlWaitN,
	output logic [saturnPkg::CpuDataWidth-1:0]      cpuRdata,
	output logic                                    waitN,
	output logic [3:0]                              memCsN,
	output logic [saturnPkg::CpuAddrWidth-1:0]      memA,
	output logic [saturnPkg::CpuDataWidth-1:0]      memDo,
	output logic [3:0]                              memDqmN,
	output logic                                    memRdN,

	input  saturnPkg::bSel_t                        bSel,
	input  logic [saturnPkg::BusDataWidth-1:0]      vdp1Data,
	input  logic [saturnPkg::BusDataWidth-1:0]      vdp2Data,
	input  logic [saturnPkg::BusDataWidth-1:0]      scspData,
	output logic [saturnPkg::BusDataWidth-1:0]      bRdata,

	input  saturnPkg::cdBus_t                       cdBus,
	input  logic [saturnPkg::BusDataWidth-1:0]      chipRdata,
	input  logic [saturnPkg::BusDataWidth-1:0]      chipWdata,
	input  logic [saturnPkg::BusDataWidth-1:0]      cdRamQ,
	input  logic                                    cdRamRdy,
	output logic [saturnPkg::BusDataWidth-1:0]      cdRdata,
	output logic                                    cdWaitN,
	output logic [saturnPkg::CdRamAddrWidth-1:0]    cdRamA,
	output logic [saturnPkg::BusDataWidth-1:0]      cdRamD,
	output logic [1:0]                              cdRamWe,
	output logic                                    cdRamRd,
	output logic                                    cdRamCs,

	output logic [7:0]                              waitCnt,
	output logic                                    hook,
	output logic [7:0]                              cdWriteCnt
);

	clockEnableGen #(
		.SmpcDivide(SmpcDivide)
	) clockEnableGen_inst (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ce        (ce),
		.pauseEn   (pauseEn),
		.ceRise    (ceRise),
		.ceFall    (ceFall),
		.smpcCe    (smpcCe),
		.masterResN(masterResN)
	);

	busArbiter busArbiter_inst (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.ceRise      (ceRise),
		.sshReqN     (sshReqN),
		.scuReqN     (scuReqN),
		.masterGrantN(masterGrantN),
		.masterRelN  (masterRelN),
		.sshAckN     (sshAckN),
		.scuAckN     (scuAckN)
	);

	systemReadMux systemReadMux_inst (
		.cpuBus   (cpuBus),
		.chipSel  (chipSel),
		.memRdata (memRdata),
		.smpcData (smpcData),
		.scuRdata (scuRdata),
		.memWaitN (memWaitN),
		.ctrlWaitN(ctrlWaitN),
		.cpuRdata (cpuRdata),
		.waitN    (waitN),
		.bSel     (bSel),
		.vdp1Data (vdp1Data),
		.vdp2Data (vdp2Data),
		.scspData (scspData),
		.bRdata   (bRdata),
		.memCsN   (memCsN)
	);

	// Sub-CPU and bridge share the main enable
	cdRamBridge cdRamBridge_inst (
		.cdBus    (cdBus),
		.chipRdata(chipRdata),
		.chipWdata(chipWdata),
		.cdRamQ   (cdRamQ),
		.cdRamRdy (cdRamRdy),
		.cdRdata  (cdRdata),
		.cdWaitN  (cdWaitN),
		.cdRamA   (cdRamA),
		.cdRamD   (cdRamD),
		.cdRamWe  (cdRamWe),
		.cdRamRd  (cdRamRd),
		.cdRamCs  (cdRamCs)
	);

	debugMonitor #(
		.HookAddr   (HookAddr),
		.CdWatchAddr(CdWatchAddr)
	) debugMonitor_inst (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.ceRise    (ceRise),
		.cpuBus    (cpuBus),
		.cdBus     (cdBus),
		.waitCnt   (waitCnt),
		.hook      (hook),
		.cdWriteCnt(cdWriteCnt)
	);

	// External memory port
	assign memA    = cpuBus.addr;
	assign memDo   = cpuBus.wdata;
	assign memDqmN = cpuBus.dqmN;
	assign memRdN  = cpuBus.rdN;

endmodule

`default_nettype wire

// ==== saturnInterconnectTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module saturnInterconnectTb;

	localparam int SmpcDivide = 7;
	localparam logic [saturnPkg::CpuAddrWidth-1:0] HookAddr = 25'h0012B0;
	localparam logic [saturnPkg::CdRamAddrWidth-1:0] CdWatchAddr = 18'h3AC0C;
	localparam int ResetCycles = 10;
	localparam int TestCycles = 3000;
	localparam int TimeoutCycles = 2 * (ResetCycles + TestCycles + 2);

	logic CLK = 1'b0;
	logic RST_N;
	logic ce, pauseEn, ceRise, ceFall, smpcCe, masterResN;
	logic sshReqN, scuReqN, masterGrantN, masterRelN, sshAckN, scuAckN;
	saturnPkg::cpuBus_t cpuBus;
	saturnPkg::chipSel_t chipSel;
	logic [31:0] memRdata, scuRdata, cpuRdata, memDo;
	logic [7:0] smpcData;
	logic memWaitN, ctrlWaitN, waitN, memRdN;
	logic [3:0] memCsN, memDqmN;
	logic [24:0] memA;
	saturnPkg::bSel_t bSel;
	logic [15:0] vdp1Data, vdp2Data, scspData, bRdata;
	saturnPkg::cdBus_t cdBus;
	logic [15:0] chipRdata, chipWdata, cdRamQ, cdRdata, cdRamD;
	logic cdRamRdy, cdWaitN, cdRamRd, cdRamCs;
	logic [17:0] cdRamA;
	logic [1:0] cdRamWe;
	logic [7:0] waitCnt, cdWriteCnt;
	logic hook;

	// Reference model state
	logic modelMclk, modelSmpcCe, modelMasterResN, modelSsh, modelScu;
	logic modelHook, modelCdWriteOld;
	logic [7:0] modelWaitCnt, modelCdWriteCnt;
	int divCount;
	int cycleCount = 0;
	logic [31:0] seed = 32'd77202;

	saturnInterconnect #(
		.SmpcDivide (SmpcDivide),
		.HookAddr   (HookAddr),
		.CdWatchAddr(CdWatchAddr)
	) saturnInterconnect_inst (.*);

	always #2 CLK = ~CLK;

	// Hang guard
	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= TimeoutCycles) begin
			$display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
			$display("SIMULATION FAILED");
			$fatal(1, "Run stopped by timeout");
		end
	end

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic nextRandom(output logic [31:0] value);
		logic [31:0] upper;
		seed = lcgNext(seed);
		upper = seed;
		seed = lcgNext(seed);
		value = {upper[31:16], seed[31:16]}; // Low LCG bits are weak
	endtask

	task automatic checkValue(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
			$display("SIMULATION FAILED");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic driveRandom();
		logic [31:0] r [0:9];
		for (int i = 0; i < 10; i++) begin
			nextRandom(r[i]);
		end
		ce           <= (r[0][1:0] != 2'b00);
		pauseEn      <= (r[0][4:2] == 3'b000);
		if (r[0][6:5] == 2'b00) sshReqN <= ~sshReqN; // Requests held for a while
		if (r[0][8:7] == 2'b00) scuReqN <= ~scuReqN;
		masterGrantN <= r[0][9];
		memWaitN     <= r[0][10];
		ctrlWaitN    <= (r[0][12:11] != 2'b00);
		cdRamRdy     <= r[0][13];
		chipSel      <= r[0][17:14];
		bSel         <= r[0][20:18];
		smpcData     <= r[0][28:21];
		cpuBus.addr  <= (r[2][29:27] == 3'b000) ? HookAddr : r[2][24:0];
		cpuBus.wdata <= r[1];
		cpuBus.dqmN  <= r[9][27] ? 4'hF : r[9][26:23];
		cpuBus.rdN   <= r[2][25];
		cpuBus.cs3N  <= r[2][26];
		memRdata     <= r[3];
		scuRdata     <= r[4];
		vdp1Data     <= r[5][15:0];
		vdp2Data     <= r[5][31:16];
		scspData     <= r[6][15:0];
		chipRdata    <= r[6][31:16];
		chipWdata    <= r[7][15:0];
		cdRamQ       <= r[7][31:16];
		cdBus.addr   <= (r[9][22:21] == 2'b00) ? {r[8][20:18], CdWatchAddr} : r[8][20:0];
		cdBus.wdata  <= r[9][15:0];
		cdBus.wrlN   <= r[9][16];
		cdBus.wrhN   <= r[9][17];
		cdBus.rdN    <= r[9][18];
		cdBus.cs1N   <= (r[9][20:19] == 2'b00);
	endtask

	// Advances the model by one CLK from the inputs the DUT samples
	task automatic updateModel();
		logic rise, cdWrite, sshNext, scuNext;
		rise = modelMclk && !pauseEn;
		cdWrite = !cdBus.wrlN || !cdBus.wrhN;
		if (modelSmpcCe) modelMasterResN = 1'b1;
		modelSmpcCe = 1'b0;
		if (rise) begin
			if (divCount == SmpcDivide - 1) begin
				divCount = 0;
				modelSmpcCe = 1'b1;
			end else begin
				divCount++;
			end
			sshNext = (!sshReqN && !modelSsh && !modelScu) ? 1'b1 : (sshReqN ? 1'b0 : modelSsh);
			scuNext = (!scuReqN && sshReqN && !modelSsh && !modelScu) ? 1'b1 :
				(scuReqN ? 1'b0 : modelScu);
			modelSsh = sshNext;
			modelScu = scuNext;
			if (cpuBus.rdN && cpuBus.dqmN == 4'hF) begin
				modelWaitCnt = 8'd0;
			end else begin
				modelWaitCnt = modelWaitCnt + 8'd1;
			end
			if (cpuBus.addr == HookAddr && !cpuBus.rdN && !cpuBus.cs3N) modelHook = 1'b1;
			if (cdWrite && !modelCdWriteOld && !cdBus.cs1N && cdBus.addr[17:0] == CdWatchAddr)
				modelCdWriteCnt = modelCdWriteCnt + 8'd1;
			modelCdWriteOld = cdWrite;
		end
		if (ce && !pauseEn) modelMclk = !modelMclk;
	endtask

	task automatic checkOutputs();
		logic memSel;
		logic [31:0] expRdata;
		logic [15:0] expB;
		logic [15:0] expCd;
		memSel = !(cpuBus.cs3N && chipSel.dramN && chipSel.romN && chipSel.sramN);
		if (memSel) expRdata = memRdata;
		else if (!chipSel.smpcN) expRdata = {4{smpcData}};
		else expRdata = scuRdata;
		if (!bSel.vdp1N) expB = vdp1Data;
		else if (!bSel.vdp2N) expB = vdp2Data;
		else if (!bSel.scspN) expB = scspData;
		else expB = 16'h0000;
		if (cdBus.cs1N) expCd = chipRdata;
		else expCd = cdRamQ;
		checkValue("clockEnable ceRise", 64'(modelMclk && !pauseEn), 64'(ceRise));
		checkValue("clockEnable ceFall", 64'(!modelMclk && !pauseEn), 64'(ceFall));
		checkValue("clockEnable smpcCe", 64'(modelSmpcCe), 64'(smpcCe));
		checkValue("clockEnable masterResN", 64'(modelMasterResN), 64'(masterResN));
		checkValue("arbiter masterRelN",
			64'(!((modelSsh && !sshReqN) || (modelScu && !scuReqN))), 64'(masterRelN));
		checkValue("arbiter sshAckN", 64'(!(!masterGrantN && modelSsh)), 64'(sshAckN));
		checkValue("arbiter scuAckN", 64'(!(!masterGrantN && modelScu)), 64'(scuAckN));
		checkValue("cpuRead cpuRdata", 64'(expRdata), 64'(cpuRdata));
		checkValue("cpuRead waitN", 64'(ctrlWaitN && (memWaitN || !memSel)), 64'(waitN));
		checkValue("cpuRead memCsN",
			64'({chipSel.romN, chipSel.sramN, chipSel.dramN, cpuBus.cs3N}), 64'(memCsN));
		checkValue("cpuRead memA", 64'(cpuBus.addr), 64'(memA));
		checkValue("cpuRead memDo", 64'(cpuBus.wdata), 64'(memDo));
		checkValue("cpuRead memDqmN", 64'(cpuBus.dqmN), 64'(memDqmN));
		checkValue("cpuRead memRdN", 64'(cpuBus.rdN), 64'(memRdN));
		checkValue("bRead bRdata", 64'(expB), 64'(bRdata));
		checkValue("cdBridge cdRamA", 64'(cdBus.addr[17:0]), 64'(cdRamA));
		checkValue("cdBridge cdRamD", 64'(chipWdata), 64'(cdRamD));
		checkValue("cdBridge cdRamWe", 64'({!cdBus.wrhN, !cdBus.wrlN}), 64'(cdRamWe));
		checkValue("cdBridge cdRamCs", 64'(!cdBus.cs1N), 64'(cdRamCs));
		checkValue("cdBridge cdRamRd", 64'(!cdBus.rdN), 64'(cdRamRd));
		checkValue("cdBridge cdRdata", 64'(expCd), 64'(cdRdata));
		checkValue("cdBridge cdWaitN", 64'(cdRamRdy), 64'(cdWaitN));
		checkValue("monitor waitCnt", 64'(modelWaitCnt), 64'(waitCnt));
		checkValue("monitor hook", 64'(modelHook), 64'(hook));
		checkValue("monitor cdWriteCnt", 64'(modelCdWriteCnt), 64'(cdWriteCnt));
	endtask

	initial begin
		RST_N = 1'b0;
		ce = 1'b0;
		pauseEn = 1'b0;
		sshReqN = 1'b1;
		scuReqN = 1'b1;
		masterGrantN = 1'b1;
		cpuBus = '1;
		chipSel = '1;
		memRdata = '0;
		smpcData = '0;
		scuRdata = '0;
		memWaitN = 1'b1;
		ctrlWaitN = 1'b1;
		bSel = '1;
		vdp1Data = '0;
		vdp2Data = '0;
		scspData = '0;
		cdBus = '1;
		chipRdata = '0;
		chipWdata = '0;
		cdRamQ = '0;
		cdRamRdy = 1'b1;
		{modelMclk, modelSmpcCe, modelMasterResN, modelSsh, modelScu} = '0;
		{modelHook, modelCdWriteOld, modelWaitCnt, modelCdWriteCnt} = '0;
		divCount = 0;

		repeat (ResetCycles) @(posedge CLK);
		RST_N <= 1'b1;
		driveRandom();
		for (int cycle = 0; cycle < TestCycles; cycle++) begin
			@(negedge CLK);
			checkOutputs();
			@(posedge CLK);
			updateModel();
			driveRandom();
		end
		@(negedge CLK);
		checkOutputs();

		checkValue("clockEnable reset release", 64'(1), 64'(masterResN));
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== saturnInterconnect.f ====
saturnPkg.sv
clockEnableGen.sv
busArbiter.sv
systemReadMux.sv
cdRamBridge.sv
debugMonitor.sv
saturnInterconnect.sv
saturnInterconnectTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f saturnInterconnect.f --top-module saturnInterconnectTb -o simTb

./obj_dir/simTb > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
	exit 0
fi
exit 1
